// File: hdl/rvfi_pkg.sv
// Retirement tracer definitions

package rvfi_pkg;

  // ------------------------------
  // Widths and depths
  // ------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_SB_ENTRIES = 8;  // Scoreboard depth
  localparam int unsigned TRANS_ID_BITS = 3;  // log2 of NR_SB_ENTRIES

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [XLEN-1:0]          xlen_t;      // Data word, operand, result, pc
  typedef logic [31:0]              insn_t;      // Instruction word
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;  // Scoreboard index
  typedef logic [XLEN/8-1:0]        be_t;        // One bit per byte lane
  typedef logic [31:0]              cause_t;     // Exception cause

  // Privilege mode as seen by the core
  // User is 0, supervisor is 1, machine is 3
  typedef logic [1:0]               priv_t;

  // Reported in place of the privilege while halted in debug
  localparam priv_t MODE_DEBUG = 2'd2;

  // ------------------------------
  // Load/store unit operation
  // ------------------------------
  typedef enum logic [1:0] {
    LSU_NONE,   // No access this cycle
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

  // ------------------------------
  // Environment call causes
  // ------------------------------
  // These traps still count as retired
  localparam cause_t CAUSE_ECALL_U = 32'd8;
  localparam cause_t CAUSE_ECALL_S = 32'd9;
  localparam cause_t CAUSE_ECALL_M = 32'd11;

endpackage

// File: hdl/lookup_if.sv
// Table lookup interfaces
`timescale 1ns/1ps

// Instruction and operand lookup
interface op_lookup_if;

  rvfi_pkg::trans_id_t ptr;        // Entry to read
  rvfi_pkg::insn_t     insn;
  rvfi_pkg::xlen_t     rs1_rdata;  // Operands as forwarded at accept
  rvfi_pkg::xlen_t     rs2_rdata;

  modport reader (output ptr, input insn, rs1_rdata, rs2_rdata);
  modport tbl    (input ptr, output insn, rs1_rdata, rs2_rdata);

endinterface

// Memory access lookup
interface mem_lookup_if;

  rvfi_pkg::trans_id_t ptr;
  rvfi_pkg::xlen_t     addr;   // Virtual address of the access
  rvfi_pkg::be_t       rmask;  // Nonzero only for loads
  rvfi_pkg::be_t       wmask;  // Nonzero only for stores
  rvfi_pkg::xlen_t     wdata;

  modport reader (output ptr, input addr, rmask, wmask, wdata);
  modport tbl    (input ptr, output addr, rmask, wmask, wdata);

endinterface

// File: hdl/issue_capture.sv
// Fetch and issue capture
`timescale 1ns/1ps

module issue_capture (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                fetch_valid_i,
  input  logic                fetch_compressed_i,
  input  logic                issue_ack_i,
  input  logic                decoded_valid_i,
  input  logic                decoded_ack_i,
  input  logic                flush_unissued_i,
  input  rvfi_pkg::insn_t     fetch_instr_i,
  input  rvfi_pkg::trans_id_t issue_ptr_i,
  input  rvfi_pkg::xlen_t     rs1_fwd_i,
  input  rvfi_pkg::xlen_t     rs2_fwd_i,
  output logic                alloc_o,
  op_lookup_if.tbl            lookup
);

  logic            latch_valid_q;
  rvfi_pkg::insn_t latch_instr_q;
  logic            latch_load;
  logic            accept;

  rvfi_pkg::insn_t insn_q [rvfi_pkg::NR_SB_ENTRIES];
  rvfi_pkg::xlen_t rs1_q  [rvfi_pkg::NR_SB_ENTRIES];
  rvfi_pkg::xlen_t rs2_q  [rvfi_pkg::NR_SB_ENTRIES];

  // ------------------------------
  // Fetch latch
  // ------------------------------
  // Takes a new fetch when empty or when the held one is issued
  assign latch_load = fetch_valid_i && (!latch_valid_q || issue_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latch_valid_q <= 1'b0;
      latch_instr_q <= '0;
    end else if (flush_i) begin
      latch_valid_q <= 1'b0;  // Flush beats a fetch
    end else if (latch_load) begin
      latch_valid_q <= 1'b1;
      // Compressed encodings keep only the low half
      latch_instr_q <= fetch_compressed_i ? {16'h0000, fetch_instr_i[15:0]} : fetch_instr_i;
    end else if (issue_ack_i) begin
      latch_valid_q <= 1'b0;
    end
  end

  // ------------------------------
  // Per-transaction table
  // ------------------------------
  assign accept  = decoded_valid_i && decoded_ack_i;
  assign alloc_o = accept && !flush_unissued_i;  // Entry really taken

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rvfi_pkg::NR_SB_ENTRIES; i++) begin
        insn_q[i] <= '0;
        rs1_q[i]  <= '0;
        rs2_q[i]  <= '0;
      end
    end else if (alloc_o) begin
      insn_q[issue_ptr_i] <= latch_instr_q;
      rs1_q[issue_ptr_i]  <= rs1_fwd_i;
      rs2_q[issue_ptr_i]  <= rs2_fwd_i;
    end
  end

  // Read port for the packer
  assign lookup.insn      = insn_q[lookup.ptr];
  assign lookup.rs1_rdata = rs1_q[lookup.ptr];
  assign lookup.rs2_rdata = rs2_q[lookup.ptr];

  // Decoder can only hand over what fetch delivered earlier
  accept_after_fetch_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> latch_valid_q
  ) else $error("Decoded instruction accepted with empty fetch latch");

endmodule

// File: hdl/lsu_capture.sv
// Load/store access capture
`timescale 1ns/1ps

module lsu_capture (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                alloc_i,
  input  rvfi_pkg::trans_id_t issue_ptr_i,
  input  rvfi_pkg::trans_id_t lsu_trans_id_i,
  input  rvfi_pkg::lsu_op_e   lsu_op_i,
  input  rvfi_pkg::be_t       lsu_be_i,
  input  rvfi_pkg::xlen_t     lsu_vaddr_i,
  input  rvfi_pkg::xlen_t     lsu_wdata_i,
  mem_lookup_if.tbl           lookup
);

  rvfi_pkg::xlen_t addr_q  [rvfi_pkg::NR_SB_ENTRIES];
  rvfi_pkg::be_t   rmask_q [rvfi_pkg::NR_SB_ENTRIES];
  rvfi_pkg::be_t   wmask_q [rvfi_pkg::NR_SB_ENTRIES];
  rvfi_pkg::xlen_t wdata_q [rvfi_pkg::NR_SB_ENTRIES];

  // ------------------------------
  // Access table
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rvfi_pkg::NR_SB_ENTRIES; i++) begin
        addr_q[i]  <= '0;
        rmask_q[i] <= '0;
        wmask_q[i] <= '0;
        wdata_q[i] <= '0;
      end
    end else begin
      // Reallocated id starts with no access recorded
      if (alloc_i) begin
        addr_q[issue_ptr_i]  <= '0;
        rmask_q[issue_ptr_i] <= '0;
        wmask_q[issue_ptr_i] <= '0;
        wdata_q[issue_ptr_i] <= '0;
      end
      // Later assignments win over the clear above
      if (lsu_op_i == rvfi_pkg::LSU_LOAD) begin
        addr_q[lsu_trans_id_i]  <= lsu_vaddr_i;
        rmask_q[lsu_trans_id_i] <= lsu_be_i;
      end else if (lsu_op_i == rvfi_pkg::LSU_STORE) begin
        addr_q[lsu_trans_id_i]  <= lsu_vaddr_i;
        wmask_q[lsu_trans_id_i] <= lsu_be_i;
        wdata_q[lsu_trans_id_i] <= lsu_wdata_i;
      end
    end
  end

  assign lookup.addr  = addr_q[lookup.ptr];
  assign lookup.rmask = rmask_q[lookup.ptr];
  assign lookup.wmask = wmask_q[lookup.ptr];
  assign lookup.wdata = wdata_q[lookup.ptr];

  // An access always touches at least one byte lane
  lsu_be_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lsu_op_i != rvfi_pkg::LSU_NONE) |-> (lsu_be_i != '0)
  ) else $error("LSU access with empty byte enable");

endmodule

// File: hdl/retire_packer.sv
// Retire record packer
`timescale 1ns/1ps

module retire_packer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                commit_valid_i,
  input  logic                commit_ack_i,
  input  logic                ex_valid_i,
  input  logic                debug_mode_i,
  input  rvfi_pkg::trans_id_t commit_ptr_i,
  input  rvfi_pkg::xlen_t     commit_pc_i,
  input  rvfi_pkg::xlen_t     commit_result_i,
  input  rvfi_pkg::xlen_t     commit_wdata_i,
  input  logic [4:0]          commit_rd_i,
  input  rvfi_pkg::cause_t    ex_cause_i,
  input  rvfi_pkg::priv_t     priv_lvl_i,
  op_lookup_if.reader         op,
  mem_lookup_if.reader        mem,
  output logic                rvfi_valid_o,
  output logic                rvfi_trap_o,
  output rvfi_pkg::insn_t     rvfi_insn_o,
  output rvfi_pkg::cause_t    rvfi_cause_o,
  output rvfi_pkg::priv_t     rvfi_mode_o,
  output rvfi_pkg::xlen_t     rvfi_pc_o,
  output rvfi_pkg::xlen_t     rvfi_rd_wdata_o,
  output rvfi_pkg::xlen_t     rvfi_rs1_rdata_o,
  output rvfi_pkg::xlen_t     rvfi_rs2_rdata_o,
  output rvfi_pkg::xlen_t     rvfi_mem_addr_o,
  output rvfi_pkg::xlen_t     rvfi_mem_wdata_o,
  output rvfi_pkg::xlen_t     rvfi_mem_rdata_o,
  output logic [4:0]          rvfi_rd_addr_o,
  output rvfi_pkg::be_t       rvfi_mem_rmask_o,
  output rvfi_pkg::be_t       rvfi_mem_wmask_o
);

  logic is_ecall;

  // Both tables are read at the committing id
  assign op.ptr  = commit_ptr_i;
  assign mem.ptr = commit_ptr_i;

  assign is_ecall = (ex_cause_i == rvfi_pkg::CAUSE_ECALL_U) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_S) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_M);

  // ------------------------------
  // Status fields
  // ------------------------------
  assign rvfi_trap_o  = commit_valid_i && ex_valid_i;
  // Environment calls retire even though they trap
  assign rvfi_valid_o = (commit_ack_i && !ex_valid_i) || (rvfi_trap_o && is_ecall);
  assign rvfi_cause_o = ex_cause_i;
  assign rvfi_mode_o  = debug_mode_i ? rvfi_pkg::MODE_DEBUG : priv_lvl_i;

  // ------------------------------
  // Payload fields
  // ------------------------------
  assign rvfi_insn_o      = op.insn;
  assign rvfi_pc_o        = commit_pc_i;
  assign rvfi_rd_addr_o   = commit_rd_i;
  assign rvfi_rd_wdata_o  = commit_wdata_i;
  assign rvfi_rs1_rdata_o = op.rs1_rdata;
  assign rvfi_rs2_rdata_o = op.rs2_rdata;
  assign rvfi_mem_addr_o  = mem.addr;
  assign rvfi_mem_rmask_o = mem.rmask;
  assign rvfi_mem_wmask_o = mem.wmask;
  assign rvfi_mem_wdata_o = mem.wdata;
  assign rvfi_mem_rdata_o = commit_result_i;  // Load data comes back as the result

  commit_ack_valid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_valid_i
  ) else $error("Commit acknowledged without a valid commit");

endmodule

// File: hdl/rvfi_tracer.sv
// Retirement tracer top level
`timescale 1ns/1ps

module rvfi_tracer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Fetch and issue probes
  input  logic                flush_i,
  input  logic                fetch_valid_i,
  input  logic                fetch_compressed_i,
  input  rvfi_pkg::insn_t     fetch_instr_i,
  input  logic                issue_ack_i,
  input  logic                decoded_valid_i,
  input  logic                decoded_ack_i,
  input  logic                flush_unissued_i,
  input  rvfi_pkg::trans_id_t issue_ptr_i,
  input  rvfi_pkg::xlen_t     rs1_fwd_i,
  input  rvfi_pkg::xlen_t     rs2_fwd_i,
  // Load/store probes
  input  rvfi_pkg::lsu_op_e   lsu_op_i,
  input  rvfi_pkg::be_t       lsu_be_i,
  input  rvfi_pkg::xlen_t     lsu_vaddr_i,
  input  rvfi_pkg::xlen_t     lsu_wdata_i,
  input  rvfi_pkg::trans_id_t lsu_trans_id_i,
  // Commit probes
  input  logic                commit_valid_i,
  input  logic                commit_ack_i,
  input  rvfi_pkg::trans_id_t commit_ptr_i,
  input  rvfi_pkg::xlen_t     commit_pc_i,
  input  rvfi_pkg::xlen_t     commit_result_i,
  input  rvfi_pkg::xlen_t     commit_wdata_i,
  input  logic [4:0]          commit_rd_i,
  input  logic                ex_valid_i,
  input  rvfi_pkg::cause_t    ex_cause_i,
  input  rvfi_pkg::priv_t     priv_lvl_i,
  input  logic                debug_mode_i,
  // Trace record
  output logic                rvfi_valid_o,
  output logic                rvfi_trap_o,
  output rvfi_pkg::insn_t     rvfi_insn_o,
  output rvfi_pkg::cause_t    rvfi_cause_o,
  output rvfi_pkg::priv_t     rvfi_mode_o,
  output rvfi_pkg::xlen_t     rvfi_pc_o,
  output rvfi_pkg::xlen_t     rvfi_rd_wdata_o,
  output rvfi_pkg::xlen_t     rvfi_rs1_rdata_o,
  output rvfi_pkg::xlen_t     rvfi_rs2_rdata_o,
  output rvfi_pkg::xlen_t     rvfi_mem_addr_o,
  output rvfi_pkg::xlen_t     rvfi_mem_wdata_o,
  output rvfi_pkg::xlen_t     rvfi_mem_rdata_o,
  output logic [4:0]          rvfi_rd_addr_o,
  output rvfi_pkg::be_t       rvfi_mem_rmask_o,
  output rvfi_pkg::be_t       rvfi_mem_wmask_o
);

  logic alloc;  // Entry allocated at issue

  op_lookup_if  op_lookup ();
  mem_lookup_if mem_lookup ();

  // ------------------------------
  // Capture side
  // ------------------------------
  issue_capture u_issue_capture (
    .clk_i, .rst_ni, .flush_i, .fetch_valid_i, .fetch_compressed_i, .issue_ack_i,
    .decoded_valid_i, .decoded_ack_i, .flush_unissued_i, .fetch_instr_i, .issue_ptr_i,
    .rs1_fwd_i, .rs2_fwd_i,
    .alloc_o (alloc),
    .lookup  (op_lookup)
  );

  lsu_capture u_lsu_capture (
    .clk_i, .rst_ni,
    .alloc_i (alloc),
    .issue_ptr_i, .lsu_trans_id_i, .lsu_op_i, .lsu_be_i, .lsu_vaddr_i, .lsu_wdata_i,
    .lookup  (mem_lookup)
  );

  // ------------------------------
  // Commit side
  // ------------------------------
  retire_packer u_retire_packer (
    .clk_i, .rst_ni, .commit_valid_i, .commit_ack_i, .ex_valid_i, .debug_mode_i,
    .commit_ptr_i, .commit_pc_i, .commit_result_i, .commit_wdata_i, .commit_rd_i,
    .ex_cause_i, .priv_lvl_i,
    .op  (op_lookup),
    .mem (mem_lookup),
    .rvfi_valid_o, .rvfi_trap_o, .rvfi_insn_o, .rvfi_cause_o, .rvfi_mode_o, .rvfi_pc_o,
    .rvfi_rd_wdata_o, .rvfi_rs1_rdata_o, .rvfi_rs2_rdata_o, .rvfi_mem_addr_o,
    .rvfi_mem_wdata_o, .rvfi_mem_rdata_o, .rvfi_rd_addr_o, .rvfi_mem_rmask_o,
    .rvfi_mem_wmask_o
  );

endmodule

// File: sim/rvfi_tracer_tb.sv
// Retirement tracer testbench
`timescale 1ns/1ps

module rvfi_tracer_tb;

  localparam int TIMEOUT_NS = 2000;  // Per wait
  localparam rvfi_pkg::lsu_op_e NONE = rvfi_pkg::LSU_NONE;
  localparam rvfi_pkg::lsu_op_e LD   = rvfi_pkg::LSU_LOAD;
  localparam rvfi_pkg::lsu_op_e ST   = rvfi_pkg::LSU_STORE;

  // DUT inputs start idle with reset held
  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic flush_i = 1'b0, fetch_valid_i = 1'b0, fetch_compressed_i = 1'b0, issue_ack_i = 1'b0;
  logic decoded_valid_i = 1'b0, decoded_ack_i = 1'b0, flush_unissued_i = 1'b0;
  logic commit_valid_i = 1'b0, commit_ack_i = 1'b0, ex_valid_i = 1'b0, debug_mode_i = 1'b0;
  rvfi_pkg::insn_t     fetch_instr_i = '0;
  rvfi_pkg::trans_id_t issue_ptr_i = '0, lsu_trans_id_i = '0, commit_ptr_i = '0;
  rvfi_pkg::xlen_t     rs1_fwd_i = '0, rs2_fwd_i = '0, lsu_vaddr_i = '0, lsu_wdata_i = '0;
  rvfi_pkg::xlen_t     commit_pc_i = '0, commit_result_i = '0, commit_wdata_i = '0;
  rvfi_pkg::lsu_op_e   lsu_op_i = rvfi_pkg::LSU_NONE;
  rvfi_pkg::be_t       lsu_be_i = '0;
  logic [4:0]          commit_rd_i = '0;
  rvfi_pkg::cause_t    ex_cause_i = '0;
  rvfi_pkg::priv_t     priv_lvl_i = 2'd3;

  // Trace record
  logic                rvfi_valid_o, rvfi_trap_o;
  rvfi_pkg::insn_t     rvfi_insn_o;
  rvfi_pkg::cause_t    rvfi_cause_o;
  rvfi_pkg::priv_t     rvfi_mode_o;
  rvfi_pkg::xlen_t     rvfi_pc_o, rvfi_rd_wdata_o, rvfi_rs1_rdata_o, rvfi_rs2_rdata_o;
  rvfi_pkg::xlen_t     rvfi_mem_addr_o, rvfi_mem_wdata_o, rvfi_mem_rdata_o;
  logic [4:0]          rvfi_rd_addr_o;
  rvfi_pkg::be_t       rvfi_mem_rmask_o, rvfi_mem_wmask_o;

  // Random fields of a stimulus row are filled when the row is added
  typedef struct packed {
    rvfi_pkg::insn_t     insn;
    logic                comp;
    rvfi_pkg::trans_id_t id;
    rvfi_pkg::lsu_op_e   op;
    rvfi_pkg::be_t       be;
    rvfi_pkg::xlen_t     addr;
    rvfi_pkg::xlen_t     wdata;
    logic                ex;
    rvfi_pkg::cause_t    cause;
    rvfi_pkg::priv_t     priv;
    logic                dbg;
    logic                fu;
    rvfi_pkg::xlen_t     rs1;
    rvfi_pkg::xlen_t     rs2;
    rvfi_pkg::xlen_t     pc;
    rvfi_pkg::xlen_t     result;
    rvfi_pkg::xlen_t     rd_wdata;
  } row_t;

  row_t rows [$];

  // Expected table contents per transaction id start cleared as after reset
  rvfi_pkg::insn_t m_insn  [8] = '{default: '0};
  rvfi_pkg::xlen_t m_rs1   [8] = '{default: '0};
  rvfi_pkg::xlen_t m_rs2   [8] = '{default: '0};
  rvfi_pkg::xlen_t m_addr  [8] = '{default: '0};
  rvfi_pkg::xlen_t m_wdata [8] = '{default: '0};
  rvfi_pkg::be_t   m_rmask [8] = '{default: '0};
  rvfi_pkg::be_t   m_wmask [8] = '{default: '0};

  int errors = 0;
  int checks = 0;
  bit timed_out = 1'b0;

  rvfi_tracer u_dut (.*);

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  task automatic add_row(input rvfi_pkg::insn_t insn, input int comp, id,
                         input rvfi_pkg::lsu_op_e op, input rvfi_pkg::be_t be,
                         input rvfi_pkg::xlen_t addr, wdata,
                         input int ex, cause, priv, dbg, fu);
    row_t r;
    r.insn     = insn;
    r.comp     = (comp != 0);
    r.id       = 3'(id);
    r.op       = op;
    r.be       = be;
    r.addr     = addr;
    r.wdata    = wdata;
    r.ex       = (ex != 0);
    r.cause    = cause;
    r.priv     = 2'(priv);
    r.dbg      = (dbg != 0);
    r.fu       = (fu != 0);
    r.rs1      = $urandom();
    r.rs2      = $urandom();
    r.pc       = $urandom();
    r.result   = $urandom();
    r.rd_wdata = $urandom();
    rows.push_back(r);
  endtask

  // Wait target 0 is a full latch, 1 an empty latch, 2 a recorded access and 3 the record
  function automatic bit reached(input int kind, input row_t r);
    case (kind)
      0:       return u_dut.u_issue_capture.latch_valid_q === 1'b1;
      1:       return u_dut.u_issue_capture.latch_valid_q === 1'b0;
      2:       return ((r.op == LD) ? rvfi_mem_rmask_o : rvfi_mem_wmask_o) === r.be;
      default: return rvfi_valid_o === 1'b1 || rvfi_trap_o === 1'b1;
    endcase
  endfunction

  task automatic wait_until(input int idx, input int kind, input row_t r, input string what);
    int t;
    t = 0;
    do begin
      #1;
      t++;
    end while (!reached(kind, r) && t < TIMEOUT_NS);
    if (!reached(kind, r)) begin
      $display("Row %0d: timeout while waiting for %s", idx, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("ERR %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    logic exp_valid;
    int   errs_before;
    r = rows[idx];
    errs_before = errors;

    // ------------------------------
    // Fetch, then ack and accept
    // ------------------------------
    fetch_valid_i      = 1'b1;
    fetch_instr_i      = r.insn;
    fetch_compressed_i = r.comp;
    wait_until(idx, 0, r, "the fetch latch to fill");
    if (timed_out) return;
    @(negedge clk_i);
    fetch_valid_i    = 1'b0;
    issue_ack_i      = 1'b1;  // Issue and accept in one cycle
    decoded_valid_i  = 1'b1;
    decoded_ack_i    = 1'b1;
    flush_unissued_i = r.fu;
    issue_ptr_i      = r.id;
    rs1_fwd_i        = r.rs1;
    rs2_fwd_i        = r.rs2;
    wait_until(idx, 1, r, "the fetch latch to empty");
    if (timed_out) return;
    @(negedge clk_i);
    issue_ack_i      = 1'b0;
    decoded_valid_i  = 1'b0;
    decoded_ack_i    = 1'b0;
    flush_unissued_i = 1'b0;
    if (!r.fu) begin  // Flushed accept leaves the old entry in place
      m_insn[r.id]  = r.comp ? {16'h0000, r.insn[15:0]} : r.insn;
      m_rs1[r.id]   = r.rs1;
      m_rs2[r.id]   = r.rs2;
      m_addr[r.id]  = '0;
      m_wdata[r.id] = '0;
      m_rmask[r.id] = '0;
      m_wmask[r.id] = '0;
    end

    // Optional memory access is seen through the lookup at this id
    if (r.op != NONE) begin
      lsu_op_i       = r.op;
      lsu_be_i       = r.be;
      lsu_vaddr_i    = r.addr;
      lsu_wdata_i    = r.wdata;
      lsu_trans_id_i = r.id;
      commit_ptr_i   = r.id;
      wait_until(idx, 2, r, "the memory access to be recorded");
      if (timed_out) return;
      @(negedge clk_i);
      lsu_op_i = NONE;
      lsu_be_i = '0;
      m_addr[r.id] = r.addr;
      if (r.op == LD) begin
        m_rmask[r.id] = r.be;
      end else begin
        m_wmask[r.id] = r.be;
        m_wdata[r.id] = r.wdata;
      end
    end

    // ------------------------------
    // Commit and check the record
    // ------------------------------
    commit_valid_i  = 1'b1;
    commit_ack_i    = !r.ex;
    ex_valid_i      = r.ex;
    ex_cause_i      = r.cause;
    commit_ptr_i    = r.id;
    commit_pc_i     = r.pc;
    commit_result_i = r.result;
    commit_wdata_i  = r.rd_wdata;
    commit_rd_i     = 5'(idx + 1);
    priv_lvl_i      = r.priv;
    debug_mode_i    = r.dbg;
    wait_until(idx, 3, r, "the trace record");
    if (timed_out) return;
    // Environment calls 8, 9 and 11 still retire
    exp_valid = !r.ex || r.cause == 32'd8 || r.cause == 32'd9 || r.cause == 32'd11;
    check_field("rvfi_valid_o", 32'(exp_valid), 32'(rvfi_valid_o));
    check_field("rvfi_trap_o", 32'(r.ex), 32'(rvfi_trap_o));
    check_field("rvfi_insn_o", m_insn[r.id], rvfi_insn_o);
    check_field("rvfi_cause_o", r.cause, rvfi_cause_o);
    check_field("rvfi_mode_o", 32'(r.dbg ? 2'd2 : r.priv), 32'(rvfi_mode_o));
    check_field("rvfi_pc_o", r.pc, rvfi_pc_o);
    check_field("rvfi_rd_addr_o", 32'(idx + 1), 32'(rvfi_rd_addr_o));
    check_field("rvfi_rd_wdata_o", r.rd_wdata, rvfi_rd_wdata_o);
    check_field("rvfi_rs1_rdata_o", m_rs1[r.id], rvfi_rs1_rdata_o);
    check_field("rvfi_rs2_rdata_o", m_rs2[r.id], rvfi_rs2_rdata_o);
    check_field("rvfi_mem_addr_o", m_addr[r.id], rvfi_mem_addr_o);
    check_field("rvfi_mem_rmask_o", 32'(m_rmask[r.id]), 32'(rvfi_mem_rmask_o));
    check_field("rvfi_mem_wmask_o", 32'(m_wmask[r.id]), 32'(rvfi_mem_wmask_o));
    check_field("rvfi_mem_wdata_o", m_wdata[r.id], rvfi_mem_wdata_o);
    check_field("rvfi_mem_rdata_o", r.result, rvfi_mem_rdata_o);
    if (errors == errs_before) begin
      $display("Row %0d id %0d: ok", idx, r.id);
    end else begin
      $display("Row %0d id %0d: %0d mismatches", idx, r.id, errors - errs_before);
    end
    @(negedge clk_i);
    commit_valid_i = 1'b0;
    commit_ack_i   = 1'b0;
    ex_valid_i     = 1'b0;
    debug_mode_i   = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h8f5c_5b12));

    // insn, comp, id, op, be, addr, wdata, ex, cause, priv, dbg, flush_unissued
    add_row(32'h00a5_0533, 0, 0, NONE, 4'h0, 0, 0, 0, 0, 3, 0, 0);
    add_row(32'hdead_4505, 1, 1, NONE, 4'h0, 0, 0, 0, 0, 3, 0, 0);  // Compressed
    add_row(32'h0045_2503, 0, 2, LD, 4'hf, 32'h8000_1000, 0, 0, 0, 3, 0, 0);
    add_row(32'h00a5_2223, 0, 3, ST, 4'h3, 32'h8000_2004, 32'hcafe_babe, 0, 0, 1, 0, 0);
    add_row(32'h0010_0093, 0, 2, NONE, 4'h0, 0, 0, 0, 0, 3, 0, 0);  // Id 2 reused
    // Only traps with an ecall cause retire
    add_row(32'h0000_0073, 0, 4, NONE, 4'h0, 0, 0, 1, 8, 0, 0, 0);
    add_row(32'hffff_ffff, 0, 5, NONE, 4'h0, 0, 0, 1, 2, 3, 0, 0);
    add_row(32'h0000_0073, 0, 6, NONE, 4'h0, 0, 0, 1, 11, 3, 0, 0);
    add_row(32'h7b20_0073, 0, 7, NONE, 4'h0, 0, 0, 0, 0, 3, 1, 0);  // In debug
    add_row(32'h1234_5037, 0, 0, NONE, 4'h0, 0, 0, 0, 0, 3, 0, 1);  // Flushed accept
    add_row(32'h0000_0073, 0, 1, NONE, 4'h0, 0, 0, 1, 9, 1, 0, 0);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_field("rvfi_valid_o after reset", 32'd0, 32'(rvfi_valid_o));
    check_field("rvfi_trap_o after reset", 32'd0, 32'(rvfi_trap_o));

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
      if (timed_out) break;
    end

    $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: all.f
hdl/rvfi_pkg.sv
hdl/lookup_if.sv
hdl/issue_capture.sv
hdl/lsu_capture.sv
hdl/retire_packer.sv
hdl/rvfi_tracer.sv
sim/rvfi_tracer_tb.sv

// File: Makefile
TOP = rvfi_tracer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

# Fails unless the pass line shows up in the simulation output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir
